/* verilog/dcache_pkg.sv */
// widths, data types and FSM encodings shared by all L1 data cache modules, imported per module
package dcache_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int BE_W       = DATA_W / 8;
  localparam int LINE_WORDS = 4;
  localparam int WORD_OFF_W = $clog2(LINE_WORDS);
  // byte position inside a word
  localparam int BYTE_OFF_W = $clog2(BE_W);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;

  // load controller
  typedef enum logic [1:0] {
    LD_IDLE,
    LD_LOOKUP,
    LD_WAIT_MISS
  } load_state_e;

  // miss unit, one Wishbone job at a time
  typedef enum logic [2:0] {
    MS_IDLE,
    MS_REFILL,
    MS_UNCACHED,
    MS_WRITE,
    MS_FLUSH
  } miss_state_e;

endpackage

/* verilog/dcache_mem.sv */
// direct-mapped tag, valid and data arrays with a registered lookup and a byte-wise hit write
module dcache_mem
  import dcache_pkg::*;
#(
  parameter int NUM_LINES = 16,
  localparam int IDX_W = $clog2(NUM_LINES),
  localparam int TAG_W = ADDR_W - IDX_W - WORD_OFF_W - BYTE_OFF_W
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  addr_t                 rd_addr_i,
  output logic                  rd_hit_o,
  output data_t                 rd_data_o,
  input  addr_t                 hit_addr_i,
  output logic                  hit_tag_match_o,
  input  logic                  hit_we_i,
  input  logic [WORD_OFF_W-1:0] hit_off_i,
  input  data_t                 hit_data_i,
  input  be_t                   hit_be_i,
  output logic                  hit_ack_o,
  input  logic                  refill_we_i,
  input  logic [IDX_W-1:0]      refill_idx_i,
  input  logic [WORD_OFF_W-1:0] refill_off_i,
  input  logic [TAG_W-1:0]      refill_tag_i,
  input  logic                  refill_last_i,
  input  data_t                 refill_data_i,
  input  logic                  inval_all_i
);

  localparam int LINE_LSB = WORD_OFF_W + BYTE_OFF_W;

  logic [NUM_LINES-1:0] valid_q;
  logic [TAG_W-1:0]     tag_q  [NUM_LINES];
  data_t                data_q [NUM_LINES][LINE_WORDS];

  logic [IDX_W-1:0]      rd_idx, hit_idx;
  logic [WORD_OFF_W-1:0] rd_off;
  logic [TAG_W-1:0]      rd_tag, hit_tag;

  // lookup stage, valid/tag/word sampled together
  logic             look_valid_q;
  logic [TAG_W-1:0] look_tag_q;
  logic [TAG_W-1:0] req_tag_q;
  data_t            look_data_q;

  assign rd_tag  = rd_addr_i[ADDR_W-1 -: TAG_W];
  assign rd_idx  = rd_addr_i[LINE_LSB +: IDX_W];
  assign rd_off  = rd_addr_i[BYTE_OFF_W +: WORD_OFF_W];
  assign hit_tag = hit_addr_i[ADDR_W-1 -: TAG_W];
  assign hit_idx = hit_addr_i[LINE_LSB +: IDX_W];

  assign rd_hit_o  = look_valid_q && (look_tag_q == req_tag_q);
  assign rd_data_o = look_data_q;

  assign hit_tag_match_o = valid_q[hit_idx] && (tag_q[hit_idx] == hit_tag);
  // a line being refilled belongs to the miss unit
  assign hit_ack_o = hit_we_i && !(refill_we_i && (refill_idx_i == hit_idx));

  //////////////////////////////
  // valid bits
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q      <= '0;
      look_valid_q <= 1'b0;
    end else begin
      look_valid_q <= valid_q[rd_idx];
      if (inval_all_i) begin
        valid_q <= '0;
      end else if (refill_we_i) begin
        // line stays invalid until its last word is in
        valid_q[refill_idx_i] <= refill_last_i;
      end
    end
  end

  //////////////////////////////
  // tags and data
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    look_tag_q  <= tag_q[rd_idx];
    req_tag_q   <= rd_tag;
    look_data_q <= data_q[rd_idx][rd_off];
    if (refill_we_i) begin
      tag_q[refill_idx_i]                <= refill_tag_i;
      data_q[refill_idx_i][refill_off_i] <= refill_data_i;
    end
    if (hit_ack_o) begin
      for (int b = 0; b < BE_W; b++) begin
        if (hit_be_i[b]) begin
          data_q[hit_idx][hit_off_i][8*b +: 8] <= hit_data_i[8*b +: 8];
        end
      end
    end
  end

  // store hit writes only into a valid line holding the store's tag
  a_hit_in_line: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    hit_we_i |-> hit_tag_match_o)
    else $error("store hit write to a line it does not match");

endmodule

/* verilog/dcache_load_ctrl.sv */
// load port controller, grants one load, looks it up and sends misses to the miss unit
module dcache_load_ctrl
  import dcache_pkg::*;
#(
  parameter int NUM_LINES = 16,
  localparam int IDX_W = $clog2(NUM_LINES),
  localparam int TAG_W = ADDR_W - IDX_W - WORD_OFF_W - BYTE_OFF_W
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  enable_i,
  input  logic  ld_req_i,
  input  addr_t ld_addr_i,
  output logic  ld_gnt_o,
  output logic  ld_rvalid_o,
  output data_t ld_rdata_o,
  input  logic  sb_valid_i,
  input  addr_t sb_addr_i,
  output addr_t rd_addr_o,
  input  logic  rd_hit_i,
  input  data_t rd_data_i,
  output logic  miss_req_o,
  output addr_t miss_addr_o,
  output logic  miss_nc_o,
  input  logic  miss_done_i,
  input  data_t miss_data_i
);

  // line address is tag plus index
  localparam int LINE_W = TAG_W + IDX_W;

  load_state_e state_q, state_d;
  addr_t       addr_q;
  logic        nc_q;
  logic        line_clash;

  // pending store to the same line holds the load back
  assign line_clash = sb_valid_i &&
                      (sb_addr_i[ADDR_W-1 -: LINE_W] == ld_addr_i[ADDR_W-1 -: LINE_W]);

  assign ld_gnt_o  = (state_q == LD_IDLE) && ld_req_i && !line_clash;
  // array is read every cycle, result used only after a grant
  assign rd_addr_o = ld_addr_i;

  assign miss_req_o  = (state_q == LD_WAIT_MISS);
  assign miss_addr_o = addr_q;
  assign miss_nc_o   = nc_q;

  assign ld_rvalid_o = ((state_q == LD_LOOKUP) && rd_hit_i) ||
                       ((state_q == LD_WAIT_MISS) && miss_done_i);
  assign ld_rdata_o  = (state_q == LD_LOOKUP) ? rd_data_i : miss_data_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      LD_IDLE: begin
        // uncached loads skip the lookup
        if (ld_gnt_o) begin
          state_d = enable_i ? LD_LOOKUP : LD_WAIT_MISS;
        end
      end
      LD_LOOKUP: begin
        state_d = rd_hit_i ? LD_IDLE : LD_WAIT_MISS;
      end
      LD_WAIT_MISS: begin
        if (miss_done_i) begin
          state_d = LD_IDLE;
        end
      end
      default: state_d = LD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= LD_IDLE;
      nc_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (ld_gnt_o) begin
        nc_q <= !enable_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ld_gnt_o) begin
      addr_q <= ld_addr_i;
    end
  end

  a_rvalid_in_flight: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ld_rvalid_o |-> $past(ld_gnt_o) || ($past(state_q) == LD_WAIT_MISS))
    else $error("load data returned with no load in flight");

endmodule

/* verilog/dcache_store_buf.sv */
// single-entry store buffer, writes store hits into the cache and sends every store to memory
module dcache_store_buf
  import dcache_pkg::*;
#(
  parameter int NUM_LINES = 16,
  localparam int IDX_W = $clog2(NUM_LINES),
  localparam int TAG_W = ADDR_W - IDX_W - WORD_OFF_W - BYTE_OFF_W
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  enable_i,
  input  logic                  st_req_i,
  input  addr_t                 st_addr_i,
  input  data_t                 st_data_i,
  input  be_t                   st_be_i,
  output logic                  st_gnt_o,
  output logic                  sb_valid_o,
  output addr_t                 sb_addr_o,
  output addr_t                 hit_addr_o,
  input  logic                  hit_tag_match_i,
  output logic                  hit_we_o,
  output logic [WORD_OFF_W-1:0] hit_off_o,
  output data_t                 hit_data_o,
  output be_t                   hit_be_o,
  input  logic                  hit_ack_i,
  output logic                  wt_req_o,
  output addr_t                 wt_addr_o,
  output data_t                 wt_data_o,
  output be_t                   wt_be_o,
  input  logic                  wt_done_i
);

  // word address, byte lanes come from the enables
  localparam int WADDR_W = TAG_W + IDX_W + WORD_OFF_W;

  logic               valid_q, hit_done_q, wt_done_q;
  logic [WADDR_W-1:0] waddr_q;
  data_t              data_q;
  be_t                be_q;
  addr_t              entry_addr;
  logic               take_store, free_entry;

  assign entry_addr = {waddr_q, {BYTE_OFF_W{1'b0}}};
  assign st_gnt_o   = !valid_q;
  assign take_store = st_req_i && st_gnt_o;

  assign sb_valid_o = valid_q;
  assign sb_addr_o  = entry_addr;

  // tag checked every cycle, so a refill finishing after capture is still patched
  assign hit_addr_o = entry_addr;
  assign hit_we_o   = valid_q && enable_i && hit_tag_match_i && !hit_done_q;
  assign hit_off_o  = waddr_q[WORD_OFF_W-1:0];
  assign hit_data_o = data_q;
  assign hit_be_o   = be_q;

  assign wt_req_o  = valid_q && !wt_done_q;
  assign wt_addr_o = entry_addr;
  assign wt_data_o = data_q;
  assign wt_be_o   = be_q;

  // memory write acknowledged and no cache write left over
  assign free_entry = valid_q && (wt_done_q || wt_done_i) && (!hit_we_o || hit_ack_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q    <= 1'b0;
      hit_done_q <= 1'b0;
      wt_done_q  <= 1'b0;
    end else if (take_store) begin
      valid_q    <= 1'b1;
      hit_done_q <= 1'b0;
      wt_done_q  <= 1'b0;
    end else if (free_entry) begin
      valid_q <= 1'b0;
    end else begin
      if (hit_we_o && hit_ack_i) begin
        hit_done_q <= 1'b1;
      end
      if (wt_done_i) begin
        wt_done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_store) begin
      waddr_q <= st_addr_i[ADDR_W-1:BYTE_OFF_W];
      data_q  <= st_data_i;
      be_q    <= st_be_i;
    end
  end

endmodule

/* verilog/dcache_miss_unit.sv */
// Wishbone classic master for line refills, uncached reads, write-through and flush
module dcache_miss_unit
  import dcache_pkg::*;
#(
  parameter int NUM_LINES = 16,
  localparam int IDX_W = $clog2(NUM_LINES),
  localparam int TAG_W = ADDR_W - IDX_W - WORD_OFF_W - BYTE_OFF_W
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flush_i,
  output logic                  flush_ack_o,
  input  logic                  sb_valid_i,
  input  logic                  wt_req_i,
  input  addr_t                 wt_addr_i,
  input  data_t                 wt_data_i,
  input  be_t                   wt_be_i,
  output logic                  wt_done_o,
  input  logic                  miss_req_i,
  input  addr_t                 miss_addr_i,
  input  logic                  miss_nc_i,
  output logic                  miss_done_o,
  output data_t                 miss_data_o,
  output logic                  refill_we_o,
  output logic [IDX_W-1:0]      refill_idx_o,
  output logic [WORD_OFF_W-1:0] refill_off_o,
  output logic [TAG_W-1:0]      refill_tag_o,
  output logic                  refill_last_o,
  output data_t                 refill_data_o,
  output logic                  inval_all_o,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output addr_t                 wb_adr_o,
  output data_t                 wb_dat_o,
  output be_t                   wb_sel_o,
  input  data_t                 wb_dat_i,
  input  logic                  wb_ack_i
);

  localparam int LINE_LSB = WORD_OFF_W + BYTE_OFF_W;
  localparam logic [WORD_OFF_W-1:0] LAST_OFF = WORD_OFF_W'(LINE_WORDS - 1);

  miss_state_e           state_q;
  logic                  cyc_q, we_q, ack, take_word;
  logic [WORD_OFF_W-1:0] cnt_q;
  addr_t                 adr_q;
  data_t                 dat_q, word_q;
  be_t                   sel_q;

  // ack counts only against our own strobe
  assign ack = cyc_q && wb_ack_i;

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_we_o  = we_q;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  assign wb_sel_o = sel_q;

  assign flush_ack_o = (state_q == MS_FLUSH);
  assign inval_all_o = (state_q == MS_FLUSH);
  assign wt_done_o   = ack && (state_q == MS_WRITE);

  // refill writes each word as it arrives
  assign refill_we_o   = ack && (state_q == MS_REFILL);
  assign refill_idx_o  = miss_addr_i[LINE_LSB +: IDX_W];
  assign refill_tag_o  = miss_addr_i[ADDR_W-1 -: TAG_W];
  assign refill_off_o  = cnt_q;
  assign refill_last_o = (cnt_q == LAST_OFF);
  assign refill_data_o = wb_dat_i;

  assign take_word = ack && ((state_q == MS_UNCACHED) ||
                     ((state_q == MS_REFILL) && (cnt_q == miss_addr_i[BYTE_OFF_W +: WORD_OFF_W])));
  assign miss_done_o = ack && ((state_q == MS_UNCACHED) ||
                               ((state_q == MS_REFILL) && (cnt_q == LAST_OFF)));
  assign miss_data_o = take_word ? wb_dat_i : word_q;

  //////////////////////////////
  // arbitration and bus FSM
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= MS_IDLE;
      cyc_q   <= 1'b0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MS_IDLE: begin
          cnt_q <= '0;
          // flush waits for the store buffer to drain
          if (flush_i && !sb_valid_i) begin
            state_q <= MS_FLUSH;
          end else if (wt_req_i) begin
            state_q <= MS_WRITE;
            cyc_q   <= 1'b1;
          end else if (miss_req_i) begin
            state_q <= miss_nc_i ? MS_UNCACHED : MS_REFILL;
            cyc_q   <= 1'b1;
          end
        end
        MS_REFILL: begin
          if (ack) begin
            cyc_q <= 1'b0;
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == LAST_OFF) begin
              state_q <= MS_IDLE;
            end
          end else if (!cyc_q) begin
            // next single read after one idle cycle
            cyc_q <= 1'b1;
          end
        end
        MS_FLUSH: state_q <= MS_IDLE;
        default: begin
          if (ack) begin
            cyc_q   <= 1'b0;
            state_q <= MS_IDLE;
          end
        end
      endcase
    end
  end

  // bus payload, loaded while idle
  always_ff @(posedge clk_i) begin
    if (take_word) begin
      word_q <= wb_dat_i;
    end
    if (state_q == MS_IDLE) begin
      dat_q <= wt_data_i;
      if (wt_req_i) begin
        adr_q <= {wt_addr_i[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
        sel_q <= wt_be_i;
        we_q  <= 1'b1;
      end else begin
        adr_q <= miss_nc_i ? {miss_addr_i[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}}
                           : {miss_addr_i[ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
        sel_q <= '1;
        we_q  <= 1'b0;
      end
    end else if (refill_we_o) begin
      adr_q[LINE_LSB-1:BYTE_OFF_W] <= cnt_q + 1'b1;
    end
  end

  a_wb_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o))
    else $error("wishbone strobe or address changed before ack");

endmodule

/* verilog/dcache_top.sv */
// L1 data cache top, instantiate with one load port, one store port and a Wishbone master
module dcache_top
  import dcache_pkg::*;
#(
  parameter int NUM_LINES = 16
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  enable_i,
  input  logic  flush_i,
  output logic  flush_ack_o,
  input  logic  ld_req_i,
  input  addr_t ld_addr_i,
  output logic  ld_gnt_o,
  output logic  ld_rvalid_o,
  output data_t ld_rdata_o,
  input  logic  st_req_i,
  input  addr_t st_addr_i,
  input  data_t st_data_i,
  input  be_t   st_be_i,
  output logic  st_gnt_o,
  output logic  wb_cyc_o,
  output logic  wb_stb_o,
  output logic  wb_we_o,
  output addr_t wb_adr_o,
  output data_t wb_dat_o,
  output be_t   wb_sel_o,
  input  data_t wb_dat_i,
  input  logic  wb_ack_i
);

  localparam int IDX_W = $clog2(NUM_LINES);
  localparam int TAG_W = ADDR_W - IDX_W - WORD_OFF_W - BYTE_OFF_W;

  // lookup path
  addr_t rd_addr;
  logic  rd_hit;
  data_t rd_data;

  // store hit path
  addr_t                 hit_addr;
  logic                  hit_tag_match, hit_we, hit_ack;
  logic [WORD_OFF_W-1:0] hit_off;
  data_t                 hit_data;
  be_t                   hit_be;

  // refill and invalidation
  logic                  refill_we, refill_last, inval_all;
  logic [IDX_W-1:0]      refill_idx;
  logic [WORD_OFF_W-1:0] refill_off;
  logic [TAG_W-1:0]      refill_tag;
  data_t                 refill_data;

  // store buffer state, write-through and load misses
  logic  sb_valid, wt_req, wt_done, miss_req, miss_nc, miss_done;
  addr_t sb_addr, wt_addr, miss_addr;
  data_t wt_data, miss_data;
  be_t   wt_be;

  dcache_mem #(.NUM_LINES(NUM_LINES)) u_mem (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .rd_addr_i(rd_addr), .rd_hit_o(rd_hit), .rd_data_o(rd_data),
    .hit_addr_i(hit_addr), .hit_tag_match_o(hit_tag_match),
    .hit_we_i(hit_we), .hit_off_i(hit_off), .hit_data_i(hit_data),
    .hit_be_i(hit_be), .hit_ack_o(hit_ack),
    .refill_we_i(refill_we), .refill_idx_i(refill_idx), .refill_off_i(refill_off),
    .refill_tag_i(refill_tag), .refill_last_i(refill_last), .refill_data_i(refill_data),
    .inval_all_i(inval_all)
  );

  dcache_load_ctrl #(.NUM_LINES(NUM_LINES)) u_load_ctrl (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .enable_i(enable_i),
    .ld_req_i(ld_req_i), .ld_addr_i(ld_addr_i), .ld_gnt_o(ld_gnt_o),
    .ld_rvalid_o(ld_rvalid_o), .ld_rdata_o(ld_rdata_o),
    .sb_valid_i(sb_valid), .sb_addr_i(sb_addr),
    .rd_addr_o(rd_addr), .rd_hit_i(rd_hit), .rd_data_i(rd_data),
    .miss_req_o(miss_req), .miss_addr_o(miss_addr), .miss_nc_o(miss_nc),
    .miss_done_i(miss_done), .miss_data_i(miss_data)
  );

  dcache_store_buf #(.NUM_LINES(NUM_LINES)) u_store_buf (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .enable_i(enable_i),
    .st_req_i(st_req_i), .st_addr_i(st_addr_i), .st_data_i(st_data_i),
    .st_be_i(st_be_i), .st_gnt_o(st_gnt_o),
    .sb_valid_o(sb_valid), .sb_addr_o(sb_addr),
    .hit_addr_o(hit_addr), .hit_tag_match_i(hit_tag_match), .hit_we_o(hit_we),
    .hit_off_o(hit_off), .hit_data_o(hit_data), .hit_be_o(hit_be), .hit_ack_i(hit_ack),
    .wt_req_o(wt_req), .wt_addr_o(wt_addr), .wt_data_o(wt_data), .wt_be_o(wt_be),
    .wt_done_i(wt_done)
  );

  dcache_miss_unit #(.NUM_LINES(NUM_LINES)) u_miss_unit (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .flush_i(flush_i), .flush_ack_o(flush_ack_o),
    .sb_valid_i(sb_valid), .wt_req_i(wt_req), .wt_addr_i(wt_addr),
    .wt_data_i(wt_data), .wt_be_i(wt_be), .wt_done_o(wt_done),
    .miss_req_i(miss_req), .miss_addr_i(miss_addr), .miss_nc_i(miss_nc),
    .miss_done_o(miss_done), .miss_data_o(miss_data),
    .refill_we_o(refill_we), .refill_idx_o(refill_idx), .refill_off_o(refill_off),
    .refill_tag_o(refill_tag), .refill_last_o(refill_last), .refill_data_o(refill_data),
    .inval_all_o(inval_all),
    .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o),
    .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i)
  );

endmodule

/* tb/tb_wb_mem.sv */
// Wishbone classic slave memory for the cache testbench, acks each strobe after one wait cycle
module tb_wb_mem
  import dcache_pkg::*;
#(
  parameter int WORDS = 128
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  cyc_i,
  input  logic  stb_i,
  input  logic  we_i,
  input  addr_t adr_i,
  input  data_t dat_i,
  input  be_t   sel_i,
  output data_t dat_o,
  output logic  ack_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int AW = $clog2(WORDS);

  data_t         mem [WORDS];
  logic          waited_q;
  logic [AW-1:0] widx;

  assign widx = adr_i[BYTE_OFF_W +: AW];

  // image depends on every bit of the word index
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = {16'(i) ^ 16'hc3a5, 16'(i * 13 + 7)};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_o    <= 1'b0;
      waited_q <= 1'b0;
    end else begin
      ack_o <= 1'b0;
      if (cyc_i && stb_i && !ack_o) begin
        waited_q <= !waited_q;
        ack_o    <= waited_q;
      end
    end
  end

  // transfer happens on the edge that raises ack
  always @(posedge clk_i) begin
    if (cyc_i && stb_i && !ack_o && waited_q) begin
      if (we_i) begin
        for (int b = 0; b < BE_W; b++) begin
          if (sel_i[b]) begin
            mem[widx][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end else begin
        dat_o <= mem[widx];
      end
    end
  end

endmodule

/* tb/tb_dcache.sv */
// testbench top for the L1 data cache, random loads, stores and flushes against a word model
module tb_dcache
  import dcache_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_LINES  = 16;
  localparam int N_OPS      = 2000;
  localparam int MAX_CYCLES = N_OPS * 40;
  localparam int MEM_WORDS  = 128;
  localparam int LINE_LSB   = WORD_OFF_W + BYTE_OFF_W;

  logic  clk, arst_n, enable, flush, flush_ack;
  logic  ld_req, ld_gnt, ld_rvalid, st_req, st_gnt;
  addr_t ld_addr, st_addr, wb_adr;
  data_t ld_rdata, st_data, wb_dat_w, wb_dat_r;
  be_t   st_be, wb_sel;
  logic  wb_cyc, wb_stb, wb_we, wb_ack;

  data_t       model [MEM_WORDS];
  // write-through expected in store grant order
  addr_t       wr_adr_q [$];
  data_t       wr_dat_q [$];
  be_t         wr_be_q  [$];
  addr_t       rd_q [$];
  logic [31:0] seed = 32'd33925;
  int          cycles = 0;
  int          flush_reqs = 0;
  int          flush_acks = 0;
  // line each cache index should hold
  addr_t       line_tag [NUM_LINES];
  logic        line_ok  [NUM_LINES];

  dcache_top #(.NUM_LINES(NUM_LINES)) u_dut (
    .clk_i(clk), .arst_n_i(arst_n), .enable_i(enable), .flush_i(flush),
    .flush_ack_o(flush_ack), .ld_req_i(ld_req), .ld_addr_i(ld_addr), .ld_gnt_o(ld_gnt),
    .ld_rvalid_o(ld_rvalid), .ld_rdata_o(ld_rdata), .st_req_i(st_req), .st_addr_i(st_addr),
    .st_data_i(st_data), .st_be_i(st_be), .st_gnt_o(st_gnt),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_dat_o(wb_dat_w), .wb_sel_o(wb_sel), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack)
  );

  tb_wb_mem #(.WORDS(MEM_WORDS)) u_wb_mem (
    .clk_i(clk), .arst_n_i(arst_n), .cyc_i(wb_cyc), .stb_i(wb_stb), .we_i(wb_we),
    .adr_i(wb_adr), .dat_i(wb_dat_w), .sel_i(wb_sel), .dat_o(wb_dat_r), .ack_o(wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic report_error(string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "first mismatch");
  endtask

  task automatic check_data(data_t got, data_t exp, string what);
    if (got !== exp) report_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_addr(addr_t got, addr_t exp, string what);
    if (got !== exp) report_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) report_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_wb_write(addr_t adr, data_t dat, be_t sel);
    addr_t exp_adr;
    data_t exp_dat;
    be_t   exp_be;
    if (wr_adr_q.size() == 0) begin
      report_error("Wishbone write with no store pending");
    end else begin
      exp_adr = wr_adr_q.pop_front();
      exp_dat = wr_dat_q.pop_front();
      exp_be  = wr_be_q.pop_front();
      if (adr !== exp_adr || dat !== exp_dat || sel !== exp_be) begin
        report_error($sformatf("write %h/%h/%h expected %h/%h/%h",
                               adr, dat, sel, exp_adr, exp_dat, exp_be));
      end
    end
  endtask

  // bus monitor, outputs settled half a cycle after the drive point
  always @(negedge clk) begin
    if (arst_n && wb_cyc && wb_stb && wb_ack) begin
      if (wb_we) begin
        check_wb_write(wb_adr, wb_dat_w, wb_sel);
      end else begin
        rd_q.push_back(wb_adr);
      end
    end
    if (arst_n && flush_ack) flush_acks++;
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  function automatic logic [31:0] rand_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {seed[15:0], seed[31:16]};
  endfunction

  // four indices with two tags each, so lines conflict
  function automatic addr_t pick_addr();
    logic [31:0] r;
    addr_t       line_no;
    r = rand_next();
    line_no = addr_t'(r[1:0]) + (r[2] ? NUM_LINES : 0);
    return (line_no << LINE_LSB) | addr_t'(r[6:3]);
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic do_load(addr_t a);
    int    lat;
    int    idx;
    logic  en, hit;
    addr_t line;
    ld_req  = 1'b1;
    ld_addr = a;
    do @(negedge clk); while (!ld_gnt);
    en   = enable;
    line = (a >> LINE_LSB) << LINE_LSB;
    idx  = int'(a >> LINE_LSB) % NUM_LINES;
    hit  = en && line_ok[idx] && (line_tag[idx] == line);
    rd_q.delete();
    tick();
    ld_req = 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!ld_rvalid);
    check_data(ld_rdata, model[int'(a >> BYTE_OFF_W) % MEM_WORDS], "load data");
    tick();
    if (hit) begin
      check_flag(lat == 1, 1'b1, "hit answered one cycle after grant");
      check_flag(rd_q.size() == 0, 1'b1, "no bus read on a hit");
    end else if (en) begin
      check_flag(rd_q.size() == LINE_WORDS, 1'b1, "refill of four reads");
      foreach (rd_q[k]) check_addr(rd_q[k], addr_t'(line + 4 * k), "refill read address");
      line_tag[idx] = line;
      line_ok[idx]  = 1'b1;
    end else begin
      check_flag(rd_q.size() == 1, 1'b1, "one uncached read");
      check_addr(rd_q[0], (a >> BYTE_OFF_W) << BYTE_OFF_W, "uncached read address");
    end
  endtask

  task automatic do_store(addr_t a, data_t d, be_t be);
    int w;
    st_req  = 1'b1;
    st_addr = a;
    st_data = d;
    st_be   = be;
    do @(negedge clk); while (!st_gnt);
    w = int'(a >> BYTE_OFF_W) % MEM_WORDS;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) model[w][8*b +: 8] = d[8*b +: 8];
    end
    wr_adr_q.push_back((a >> BYTE_OFF_W) << BYTE_OFF_W);
    wr_dat_q.push_back(d);
    wr_be_q.push_back(be);
    tick();
    st_req = 1'b0;
  endtask

  task automatic do_flush();
    flush = 1'b1;
    flush_reqs++;
    do @(negedge clk); while (!flush_ack);
    tick();
    flush = 1'b0;
    foreach (line_ok[i]) line_ok[i] = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    addr_t       a;
    arst_n  = 1'b0;
    enable  = 1'b1;
    flush   = 1'b0;
    ld_req  = 1'b0;
    ld_addr = '0;
    st_req  = 1'b0;
    st_addr = '0;
    st_data = '0;
    st_be   = '0;
    foreach (line_ok[i]) line_ok[i] = 1'b0;
    repeat (2) @(posedge clk);
    #1 arst_n = 1'b1;
    @(negedge clk);
    foreach (model[i]) model[i] = u_wb_mem.mem[i];
    check_flag(ld_gnt, 1'b0, "load grant after reset");
    check_flag(ld_rvalid, 1'b0, "load valid after reset");
    check_flag(flush_ack, 1'b0, "flush ack after reset");
    check_flag(wb_cyc, 1'b0, "bus cycle after reset");
    check_flag(wb_stb, 1'b0, "bus strobe after reset");
    check_flag(st_gnt, 1'b1, "store grant after reset");
    tick();
    for (int n = 0; n < N_OPS; n++) begin
      r = rand_next();
      // stores made while off skip the cache, so lines may be stale when it comes back
      if (r[13:8] == 6'd0) begin
        enable = !enable;
        if (enable) do_flush();
      end
      a = pick_addr();
      if (r[3:0] == 4'd0) begin
        do_flush();
      end else if (r[3:0] < 4'd7) begin
        do_store(a, rand_next(), be_t'(r[19:16]));
        if (r[20]) do_load(a);
      end else begin
        do_load(a);
      end
    end
    // last store still draining
    do @(negedge clk); while (!st_gnt || wb_cyc);
    tick();
    if (wr_adr_q.size() != 0 || flush_acks != flush_reqs) begin
      $display("run ended with %0d store writes missing and %0d of %0d flushes acknowledged",
               wr_adr_q.size(), flush_acks, flush_reqs);
      $display("Test failed");
      $fatal(1, "incomplete run");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

/* vlog.f */
verilog/dcache_pkg.sv
verilog/dcache_mem.sv
verilog/dcache_load_ctrl.sv
verilog/dcache_store_buf.sv
verilog/dcache_miss_unit.sv
verilog/dcache_top.sv
tb/tb_wb_mem.sv
tb/tb_dcache.sv
